/* hw/isa_pkg.sv */
`default_nettype none

package isa_pkg;

    localparam int unsigned NAME_BITS = 5;
    localparam int unsigned DATA_BITS = 32;
    localparam int unsigned ADDR_BITS = 32;
    localparam int unsigned OP_BITS   = 7;

    // architectural register index, x0..x31
    typedef logic [NAME_BITS-1:0] reg_name_t;

    typedef logic [DATA_BITS-1:0] data_t;

    typedef logic [ADDR_BITS-1:0] addr_t;

    // major opcode, instr[6:0]
    typedef logic [OP_BITS-1:0] op_t;

    // sb, sh and sw all share this major opcode
    localparam op_t OP_STORE = 7'b0100011;

    // only stores wait for the load/store buffer before retiring
    function automatic logic is_store_op(op_t op);
        return op == OP_STORE;
    endfunction

endpackage

`default_nettype wire

/* hw/rob_pkg.sv */
`default_nettype none

package rob_pkg;

    localparam int unsigned ROB_DEPTH = 31;
    localparam int unsigned TAG_BITS  = 5;

    // tag 0 is reserved for "no tag"
    typedef logic [TAG_BITS-1:0] tag_t;

    // occupancy 0..ROB_DEPTH
    typedef logic [TAG_BITS-1:0] count_t;

    localparam tag_t   TAG_NONE  = '0;
    localparam tag_t   TAG_FIRST = tag_t'(1);
    localparam tag_t   TAG_LAST  = tag_t'(ROB_DEPTH);
    localparam count_t ROB_FULL  = count_t'(ROB_DEPTH);

    typedef struct packed {
        logic               valid;
        isa_pkg::reg_name_t rd;
        isa_pkg::op_t       op;
        logic               predicted;
    } alloc_req_t;

    typedef struct packed {
        logic           valid;
        tag_t           tag;
        isa_pkg::data_t data;
        logic           taken;
        isa_pkg::addr_t target;
    } ex_wb_t;

    typedef struct packed {
        logic           valid;
        tag_t           tag;
        isa_pkg::data_t data;
    } lsb_wb_t;

    typedef struct packed {
        logic               valid;
        isa_pkg::reg_name_t rd;
        tag_t               tag;
        isa_pkg::data_t     data;
    } rf_write_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } store_go_t;

    typedef struct packed {
        logic           valid;
        isa_pkg::addr_t target;
    } redirect_t;

    typedef struct packed {
        logic               busy;
        logic               done;
        logic               is_store;
        logic               predicted;
        logic               taken;
        isa_pkg::reg_name_t rd;
        isa_pkg::data_t     data;
        isa_pkg::addr_t     target;
    } rob_entry_t;

endpackage

`default_nettype wire

/* hw/rob_alloc.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_alloc (
    input  logic                clk,
    input  logic                rst,
    input  rob_pkg::alloc_req_t alloc,
    input  logic                retire,
    input  logic                flush,
    output logic                grant,
    output rob_pkg::tag_t       alloc_tag,
    output logic                full
);

    import rob_pkg::*;

    tag_t   tail;
    tag_t   next_tail;
    count_t count;

    assign full      = count == ROB_FULL;
    assign grant     = alloc.valid && !full;
    assign alloc_tag = grant ? tail : TAG_NONE;

    // tags run 1..31 and skip the reserved 0
    assign next_tail = (tail == TAG_LAST) ? TAG_FIRST : tag_t'(tail + 1'b1);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            tail  <= TAG_FIRST;
            count <= '0;
        end else begin
            if (grant) begin
                tail <= next_tail;
            end
            // allocate and retire in one cycle leaves count as is
            case ({grant, retire})
                2'b10:   count <= count_t'(count + 1'b1);
                2'b01:   count <= count_t'(count - 1'b1);
                default: count <= count;
            endcase
        end
    end

    // commit never retires more entries than were granted
    assert property (@(posedge clk) disable iff (rst)
        retire |-> count != '0)
        else $error("rob_alloc: retire with no occupied entry");

endmodule

`default_nettype wire

/* hw/rob_table.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_table (
    input  logic                clk,
    input  logic                rst,
    input  logic                grant,
    input  rob_pkg::tag_t       alloc_tag,
    input  rob_pkg::alloc_req_t alloc,
    input  rob_pkg::ex_wb_t     ex_wb,
    input  rob_pkg::lsb_wb_t    lsb_wb,
    input  rob_pkg::tag_t       head_tag,
    input  logic                retire,
    input  logic                flush,
    output rob_pkg::rob_entry_t head
);

    import isa_pkg::*;
    import rob_pkg::*;

    // slot 0 stays empty, tags address the table directly
    logic [ROB_DEPTH:0] busy;
    logic [ROB_DEPTH:0] done;
    logic [ROB_DEPTH:0] is_store;
    logic [ROB_DEPTH:0] predicted;
    logic [ROB_DEPTH:0] taken;

    reg_name_t rd_mem     [0:ROB_DEPTH];
    data_t     data_mem   [0:ROB_DEPTH];
    addr_t     target_mem [0:ROB_DEPTH];

    logic ex_hit;
    logic lsb_hit;

    // stale tags are dropped
    assign ex_hit  = ex_wb.valid && busy[ex_wb.tag];
    assign lsb_hit = lsb_wb.valid && busy[lsb_wb.tag];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy <= '0;
            done <= '0;
        end else begin
            if (retire) begin
                busy[head_tag] <= 1'b0;
                done[head_tag] <= 1'b0;
            end
            if (grant) begin
                busy[alloc_tag] <= 1'b1;
                done[alloc_tag] <= 1'b0;
            end
            if (ex_hit) begin
                done[ex_wb.tag] <= 1'b1;
            end
            if (lsb_hit) begin
                done[lsb_wb.tag] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            rd_mem[alloc_tag]    <= alloc.rd;
            is_store[alloc_tag]  <= is_store_op(alloc.op);
            predicted[alloc_tag] <= alloc.predicted;
            // stores never see ex_wb, so outcome starts as not taken
            taken[alloc_tag]     <= 1'b0;
        end
        if (ex_hit) begin
            data_mem[ex_wb.tag]   <= ex_wb.data;
            taken[ex_wb.tag]      <= ex_wb.taken;
            target_mem[ex_wb.tag] <= ex_wb.target;
        end
        if (lsb_hit) begin
            data_mem[lsb_wb.tag] <= lsb_wb.data;
        end
    end

    always_comb begin
        head.busy      = busy[head_tag];
        head.done      = done[head_tag];
        head.is_store  = is_store[head_tag];
        head.predicted = predicted[head_tag];
        head.taken     = taken[head_tag];
        head.rd        = rd_mem[head_tag];
        head.data      = data_mem[head_tag];
        head.target    = target_mem[head_tag];
    end

    assert property (@(posedge clk) disable iff (rst)
        ex_wb.valid |-> busy[ex_wb.tag])
        else $error("rob_table: execute writeback to idle tag %0d", ex_wb.tag);

    assert property (@(posedge clk) disable iff (rst)
        lsb_wb.valid |-> busy[lsb_wb.tag])
        else $error("rob_table: lsb writeback to idle tag %0d", lsb_wb.tag);

endmodule

`default_nettype wire

/* hw/rob_commit.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_commit (
    input  logic                clk,
    input  logic                rst,
    input  rob_pkg::rob_entry_t head,
    output rob_pkg::tag_t       head_tag,
    output logic                retire,
    output logic                flush,
    output rob_pkg::rf_write_t  rf_write,
    output rob_pkg::store_go_t  store_go,
    output rob_pkg::redirect_t  redirect
);

    import rob_pkg::*;

    tag_t released_tag;
    tag_t next_head;
    logic release_store;

    assign retire = head.busy && head.done;

    // mispredicted head, drop everything younger
    assign flush = retire && (head.taken != head.predicted);

    // each store is released once while it sits at the head
    assign release_store = head.busy && head.is_store && !head.done
                           && (released_tag != head_tag);

    assign next_head = (head_tag == TAG_LAST) ? TAG_FIRST : tag_t'(head_tag + 1'b1);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_tag     <= TAG_FIRST;
            released_tag <= TAG_NONE;
        end else if (retire) begin
            head_tag     <= next_head;
            released_tag <= TAG_NONE;
        end else if (release_store) begin
            released_tag <= head_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            rf_write.valid <= 1'b0;
            store_go.valid <= 1'b0;
            redirect.valid <= 1'b0;
        end else begin
            // stores retire without a register write
            rf_write.valid <= retire && !head.is_store;
            store_go.valid <= release_store;
            redirect.valid <= flush;
        end
        if (retire) begin
            rf_write.rd     <= head.rd;
            rf_write.tag    <= head_tag;
            rf_write.data   <= head.data;
            redirect.target <= head.target;
        end
        if (release_store) begin
            store_go.tag <= head_tag;
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        !(redirect.valid && store_go.valid))
        else $error("rob_commit: redirect and store release in the same cycle");

endmodule

`default_nettype wire

/* hw/rob_top.sv */
`timescale 1ns/1ps
`default_nettype none

module rob_top (
    input  logic                clk,
    input  logic                rst,
    input  rob_pkg::alloc_req_t alloc,
    input  rob_pkg::ex_wb_t     ex_wb,
    input  rob_pkg::lsb_wb_t    lsb_wb,
    output rob_pkg::tag_t       alloc_tag,
    output logic                full,
    output rob_pkg::rf_write_t  rf_write,
    output rob_pkg::store_go_t  store_go,
    output rob_pkg::redirect_t  redirect
);

    import rob_pkg::*;

    logic       grant;
    logic       retire;
    logic       flush;
    tag_t       head_tag;
    rob_entry_t head;

    // decode: tag allocation
    rob_alloc i_rob_alloc (
        .clk       (clk),
        .rst       (rst),
        .alloc     (alloc),
        .retire    (retire),
        .flush     (flush),
        .grant     (grant),
        .alloc_tag (alloc_tag),
        .full      (full)
    );

    // execute: entries and writeback
    rob_table i_rob_table (
        .clk       (clk),
        .rst       (rst),
        .grant     (grant),
        .alloc_tag (alloc_tag),
        .alloc     (alloc),
        .ex_wb     (ex_wb),
        .lsb_wb    (lsb_wb),
        .head_tag  (head_tag),
        .retire    (retire),
        .flush     (flush),
        .head      (head)
    );

    // result: in-order commit
    rob_commit i_rob_commit (
        .clk      (clk),
        .rst      (rst),
        .head     (head),
        .head_tag (head_tag),
        .retire   (retire),
        .flush    (flush),
        .rf_write (rf_write),
        .store_go (store_go),
        .redirect (redirect)
    );

endmodule

`default_nettype wire

/* test/tb_rob.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_rob;

    import isa_pkg::*;
    import rob_pkg::*;

    localparam int unsigned WAIT_LIMIT = 64;
    localparam op_t OP_ALU = 7'b0110011;

    typedef struct packed {
        reg_name_t rd;
        tag_t      tag;
        data_t     data;
        logic      redir;
        addr_t     target;
    } commit_rec_t;

    logic        clk;
    logic        rst;
    alloc_req_t  alloc;
    ex_wb_t      ex_wb;
    lsb_wb_t     lsb_wb;
    tag_t        alloc_tag;
    logic        full;
    rf_write_t   rf_write;
    store_go_t   store_go;
    redirect_t   redirect;

    commit_rec_t seen;
    commit_rec_t writes[$];
    tag_t        releases[$];
    int          errors;
    int          timeouts;
    int unsigned seed;

    rob_top i_rob_top (
        .clk       (clk),
        .rst       (rst),
        .alloc     (alloc),
        .ex_wb     (ex_wb),
        .lsb_wb    (lsb_wb),
        .alloc_tag (alloc_tag),
        .full      (full),
        .rf_write  (rf_write),
        .store_go  (store_go),
        .redirect  (redirect)
    );

    always #5 clk = ~clk;

    // registered commit outputs are settled by the falling edge
    always @(negedge clk) begin
        if (!rst && rf_write.valid) begin
            seen.rd     = rf_write.rd;
            seen.tag    = rf_write.tag;
            seen.data   = rf_write.data;
            seen.redir  = redirect.valid;
            seen.target = redirect.target;
            writes.push_back(seen);
        end
        if (!rst && store_go.valid) begin
            releases.push_back(store_go.tag);
        end
        if (!rst) begin
            assert (!(redirect.valid && !rf_write.valid)) else begin
                errors++;
                $display("redirect raised without a register write at %0t", $time);
            end
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic report_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        errors++;
        $display("Fail %0t: %s is %0h, expected %0h", $time, what, got, exp);
    endtask

    task automatic check_field_count(input int got, input int want);
        assert (got == want) else begin
            errors++;
            $display("malformed line in the stimulus file, read %0d of %0d fields", got, want);
        end
    endtask

    // exp_tag of 0 means the request must be refused
    task automatic allocate_one(input reg_name_t rd, input op_t op, input logic pred,
                                input tag_t exp_tag);
        next_cycle();
        alloc.valid     = 1'b1;
        alloc.rd        = rd;
        alloc.op        = op;
        alloc.predicted = pred;
        @(negedge clk);
        assert (alloc_tag == exp_tag)
            else report_value("alloc_tag", 32'(alloc_tag), 32'(exp_tag));
        next_cycle();
        alloc.valid = 1'b0;
    endtask

    task automatic expect_write(input reg_name_t rd, input tag_t tag, input data_t data,
                                input logic redir, input addr_t target);
        commit_rec_t rec;
        int cycles;
        cycles = 0;
        while (writes.size() == 0 && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (writes.size() == 0) begin
            timeouts++;
            $display("timed out waiting for the register write of tag %0d", tag);
        end else begin
            rec = writes.pop_front();
            assert (rec.tag == tag) else report_value("rf_write.tag", 32'(rec.tag), 32'(tag));
            assert (rec.rd == rd) else report_value("rf_write.rd", 32'(rec.rd), 32'(rd));
            assert (rec.data == data) else report_value("rf_write.data", rec.data, data);
            assert (rec.redir == redir)
                else report_value("redirect.valid", 32'(rec.redir), 32'(redir));
            if (redir) begin
                assert (rec.target == target)
                    else report_value("redirect.target", rec.target, target);
            end
        end
    endtask

    task automatic expect_release(input tag_t tag);
        tag_t got;
        int cycles;
        cycles = 0;
        while (releases.size() == 0 && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (releases.size() == 0) begin
            timeouts++;
            $display("timed out waiting for the store release of tag %0d", tag);
        end else begin
            got = releases.pop_front();
            assert (got == tag) else report_value("store_go.tag", 32'(got), 32'(tag));
        end
    endtask

    task automatic expect_quiet(input int cycles);
        repeat (cycles) @(posedge clk);
        assert (writes.size() == 0) else begin
            errors++;
            $display("unexpected register write of tag %0d", writes[0].tag);
            writes.delete();
        end
        assert (releases.size() == 0) else begin
            errors++;
            $display("unexpected store release of tag %0d", releases[0]);
            releases.delete();
        end
    endtask

    initial begin
        int fd;
        int n;
        int ch;
        logic [7:0]  cmd;
        logic [31:0] f0, f1, f2, f3, f4;
        tag_t t;
        seed     = $urandom(32'h9e2);
        clk      = 1'b0;
        rst      = 1'b1;
        alloc    = '0;
        ex_wb    = '0;
        lsb_wb   = '0;
        errors   = 0;
        timeouts = 0;
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;

        fd = $fopen("test/rob_stimulus.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("could not open the stimulus file");
        end else begin
            while ($fscanf(fd, " %c", cmd) == 1) begin
                if (cmd == "#") begin
                    ch = $fgetc(fd);
                    while (ch != 10 && ch != -1) begin
                        ch = $fgetc(fd);
                    end
                end else begin
                    repeat ($urandom % 3) next_cycle();
                    case (cmd)
                        "A": begin
                            n = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
                            check_field_count(n, 4);
                            allocate_one(reg_name_t'(f0), op_t'(f1), f2[0], tag_t'(f3));
                        end
                        "M": begin
                            n = $fscanf(fd, "%h %h", f0, f1);
                            check_field_count(n, 2);
                            t = tag_t'(f1);
                            repeat (f0) begin
                                allocate_one(reg_name_t'(1), OP_ALU, 1'b0, t);
                                // next tag in 1..31
                                t = tag_t'(int'(t) % ROB_DEPTH + 1);
                            end
                        end
                        "E": begin
                            n = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
                            check_field_count(n, 4);
                            next_cycle();
                            ex_wb.valid  = 1'b1;
                            ex_wb.tag    = tag_t'(f0);
                            ex_wb.data   = f1;
                            ex_wb.taken  = f2[0];
                            ex_wb.target = f3;
                            next_cycle();
                            ex_wb.valid = 1'b0;
                        end
                        "L": begin
                            n = $fscanf(fd, "%h %h", f0, f1);
                            check_field_count(n, 2);
                            next_cycle();
                            lsb_wb.valid = 1'b1;
                            lsb_wb.tag   = tag_t'(f0);
                            lsb_wb.data  = f1;
                            next_cycle();
                            lsb_wb.valid = 1'b0;
                        end
                        "W": begin
                            n = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
                            check_field_count(n, 5);
                            expect_write(reg_name_t'(f0), tag_t'(f1), f2, f3[0], f4);
                        end
                        "S": begin
                            n = $fscanf(fd, "%h", f0);
                            check_field_count(n, 1);
                            expect_release(tag_t'(f0));
                        end
                        "N": begin
                            n = $fscanf(fd, "%h", f0);
                            check_field_count(n, 1);
                            expect_quiet(int'(f0));
                        end
                        "F": begin
                            n = $fscanf(fd, "%h", f0);
                            check_field_count(n, 1);
                            @(negedge clk);
                            assert (full == f0[0]) else report_value("full", 32'(full), f0);
                        end
                        default: begin
                            errors++;
                            $display("unknown command '%c' in the stimulus file", cmd);
                        end
                    endcase
                end
            end
            $fclose(fd);
        end

        $display("checks done with %0d errors and %0d timeouts", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* test/rob_stimulus.txt */
# fields in hex: A rd op pred tag | M count first_tag | E tag data taken target
# L tag data | W rd tag data redir target | S tag | N cycles | F full
N 4
F 0
# fill all 31 entries, a request while full is refused
M 1f 01
F 1
A 05 33 0 00
N 3
F 1
# tag 1 retires and the tail wraps back to 1
E 01 00000011 0 00000000
W 01 01 00000011 0 00000000
F 0
A 07 33 0 01
# mispredicted tag 2 flushes everything younger
E 02 00000022 1 00000200
W 01 02 00000022 1 00000200
N 4
F 0
# out of order writebacks, in order retirement
A 0a 33 0 01
A 0b 33 0 02
A 0c 33 0 03
E 03 000000c3 0 00000000
N 3
E 01 000000a1 0 00000000
W 0a 01 000000a1 0 00000000
E 02 000000b2 0 00000000
W 0b 02 000000b2 0 00000000
W 0c 03 000000c3 0 00000000
# store released once, retires silently
A 00 23 0 04
A 0d 33 0 05
E 05 000000d5 0 00000000
S 04
N 3
L 04 00000000
W 0d 05 000000d5 0 00000000
# correctly predicted taken branch
A 0e 63 1 06
A 0f 33 0 07
E 06 000000e6 1 00000300
E 07 000000f7 0 00000000
W 0e 06 000000e6 0 00000000
W 0f 07 000000f7 0 00000000
N 3
F 0

/* all.f */
hw/isa_pkg.sv
hw/rob_pkg.sv
hw/rob_alloc.sv
hw/rob_table.sv
hw/rob_commit.sv
hw/rob_top.sv
test/tb_rob.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_rob
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := Simulation failed

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "test failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
